// ==== src/retire_params.svh ====
// ----------------------------------------------------------------------
// sizes for the retire trace; queue depth must be a power of two
// ----------------------------------------------------------------------
`ifndef RETIRE_PARAMS_SVH
`define RETIRE_PARAMS_SVH

// two commit ports
`define RETIRE_PORTS 2

// trace queue entries
`define RETIRE_QDEPTH 8

// counter, pc and cause widths
`define RETIRE_CNT_W 32
`define RETIRE_PC_W 64
`define RETIRE_CAUSE_W 6

`endif

// ==== src/retire_pkg.sv ====
// ----------------------------------------------------------------------
// commit side types, sized from retire_params.svh
// ----------------------------------------------------------------------
`include "retire_params.svh"

package retire_pkg;

  // execution mode tag carried by each trace entry
  typedef enum logic [1:0] {
    MODE_U = 2'b00,
    MODE_S = 2'b01,
    MODE_M = 2'b10,
    MODE_D = 2'b11
  } mode_e;

  // risc-v privilege encodings with 2'b10 reserved
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

  typedef struct packed {
    logic                       ack;
    logic [`RETIRE_PC_W-1:0]    pc;
    logic                       ex_valid;
    logic [`RETIRE_CAUSE_W-1:0] ex_cause;
  } commit_port_t;

  typedef struct packed {
    logic [`RETIRE_PC_W-1:0] pc;
    mode_e                   mode;
  } trace_entry_t;

endpackage

// ==== src/perf_pkg.sv ====
// ----------------------------------------------------------------------
// counter types; address 2'b11 is unused and reads as zero
// ----------------------------------------------------------------------
`include "retire_params.svh"

package perf_pkg;

  // read addresses of the counters
  typedef enum logic [1:0] {
    PERF_CYCLE   = 2'b00,
    PERF_INSTRET = 2'b01,
    PERF_EXCEPT  = 2'b10
  } perf_addr_e;

  typedef logic [`RETIRE_CNT_W-1:0] perf_cnt_t;

endpackage

// ==== src/retire_ifs.sv ====
// ----------------------------------------------------------------------
// internal links between retire_ctrl and the two datapath blocks
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "retire_params.svh"

// one push strobe and one trace entry per commit port
interface retire_push_if;
  import retire_pkg::*;

  logic         [`RETIRE_PORTS-1:0] push;
  trace_entry_t [`RETIRE_PORTS-1:0] entry;

  modport ctrl (
    output push,
    output entry
  );

  modport queue (
    input push,
    input entry
  );
endinterface

// counter events as levels sampled every clock edge
interface perf_event_if;
  logic [$clog2(`RETIRE_PORTS + 1)-1:0] retired;
  logic [$clog2(`RETIRE_PORTS + 1)-1:0] excepted;
  logic                                 freeze;
  logic                                 tick;

  modport ctrl (
    output retired,
    output excepted,
    output freeze,
    output tick
  );

  modport cnt (
    input retired,
    input excepted,
    input freeze,
    input tick
  );
endinterface

// ==== src/retire_ctrl.sv ====
// ----------------------------------------------------------------------
// classifies commit ports; reserved privilege code is traced as machine
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "retire_params.svh"

module retire_ctrl (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  retire_pkg::commit_port_t [`RETIRE_PORTS-1:0] commit_i,
  input  retire_pkg::priv_lvl_e                         priv_lvl_i,
  input  logic                                          debug_mode_i,
  retire_push_if.ctrl                                   push,
  perf_event_if.ctrl                                    events
);
  import retire_pkg::*;

  localparam int unsigned EV_W = $clog2(`RETIRE_PORTS + 1);

  mode_e           cur_mode;
  logic [EV_W-1:0] n_ret;
  logic [EV_W-1:0] n_exc;
  logic            tick_q;

  // debug overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      cur_mode = MODE_D;
    end else begin
      case (priv_lvl_i)
        PRIV_U:  cur_mode = MODE_U;
        PRIV_S:  cur_mode = MODE_S;
        default: cur_mode = MODE_M;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // per port push and event counts
  // ------------------------------------------------------------------
  always_comb begin
    n_ret = '0;
    n_exc = '0;
    for (int i = 0; i < `RETIRE_PORTS; i++) begin
      push.push[i]       = commit_i[i].ack & ~commit_i[i].ex_valid;
      push.entry[i].pc   = commit_i[i].pc;
      push.entry[i].mode = cur_mode;
      if (commit_i[i].ack) begin
        if (commit_i[i].ex_valid) begin
          n_exc = n_exc + EV_W'(1);
        end else begin
          n_ret = n_ret + EV_W'(1);
        end
      end
    end
  end

  // tick goes high on the first edge after reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tick_q <= 1'b0;
    end else begin
      tick_q <= 1'b1;
    end
  end

  assign events.retired  = n_ret;
  assign events.excepted = n_exc;
  assign events.freeze   = debug_mode_i;
  assign events.tick     = tick_q;

endmodule

// ==== src/pc_queue.sv ====
// ----------------------------------------------------------------------
// no back-pressure; pushes that do not fit are lost and set overflow_o
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "retire_params.svh"

module pc_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  retire_push_if.queue             push,
  output logic                     trace_valid_o,
  output retire_pkg::trace_entry_t trace_entry_o,
  output logic                     overflow_o
);
  import retire_pkg::*;

  localparam int unsigned PTR_W = $clog2(`RETIRE_QDEPTH);
  localparam int unsigned CNT_W = $clog2(`RETIRE_QDEPTH + 1);

  trace_entry_t mem_q [`RETIRE_QDEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             valid_q;
  logic             overflow_q;
  trace_entry_t     head_q;

  logic                     pop;
  logic [CNT_W-1:0]         free;
  logic [CNT_W-1:0]         n_acc;
  logic [CNT_W-1:0]         remain;
  logic                     drop;
  logic [`RETIRE_PORTS-1:0] acc;
  logic [PTR_W-1:0]         slot [`RETIRE_PORTS];
  trace_entry_t             first_entry;
  trace_entry_t             head_next;

  // ------------------------------------------------------------------
  // pop when not empty and accept pushes in port order into free slots
  // ------------------------------------------------------------------
  always_comb begin
    pop   = (count_q != '0);
    free  = CNT_W'(`RETIRE_QDEPTH) - count_q + CNT_W'(pop);
    n_acc = '0;
    drop  = 1'b0;
    for (int i = 0; i < `RETIRE_PORTS; i++) begin
      acc[i]  = 1'b0;
      slot[i] = wr_ptr_q + n_acc[PTR_W-1:0];
      if (push.push[i]) begin
        if (n_acc < free) begin
          acc[i] = 1'b1;
          n_acc  = n_acc + CNT_W'(1);
        end else begin
          drop = 1'b1;
        end
      end
    end
  end

  // lowest accepted port becomes head when nothing else is left
  always_comb begin
    first_entry = push.entry[0];
    for (int i = `RETIRE_PORTS - 1; i >= 0; i--) begin
      if (acc[i]) begin
        first_entry = push.entry[i];
      end
    end
  end

  // head after this edge; the popped slot is never the next head
  assign remain    = count_q - CNT_W'(pop);
  assign head_next = (remain != '0) ? mem_q[rd_ptr_q + PTR_W'(pop)] : first_entry;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      valid_q    <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      rd_ptr_q   <= rd_ptr_q + PTR_W'(pop);
      wr_ptr_q   <= wr_ptr_q + n_acc[PTR_W-1:0];
      count_q    <= remain + n_acc;
      valid_q    <= ((remain + n_acc) != '0);
      overflow_q <= overflow_q | drop;
    end
  end

  // storage and head entry
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `RETIRE_PORTS; i++) begin
      if (acc[i]) begin
        mem_q[slot[i]] <= push.entry[i];
      end
    end
    head_q <= head_next;
  end

  assign trace_valid_o = valid_q;
  assign trace_entry_o = head_q;
  assign overflow_o    = overflow_q;

endmodule

// ==== src/perf_counters.sv ====
// ----------------------------------------------------------------------
// counters wrap silently and are frozen while in debug mode
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "retire_params.svh"

module perf_counters (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  perf_event_if.cnt            events,
  input  perf_pkg::perf_addr_e perf_addr_i,
  output perf_pkg::perf_cnt_t  perf_rdata_o
);
  import perf_pkg::*;

  perf_cnt_t cycle_q;
  perf_cnt_t instret_q;
  perf_cnt_t except_q;

  // ------------------------------------------------------------------
  // counter update
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q   <= '0;
      instret_q <= '0;
      except_q  <= '0;
    end else if (!events.freeze) begin
      if (events.tick) begin
        cycle_q <= cycle_q + perf_cnt_t'(1);
      end
      instret_q <= instret_q + perf_cnt_t'(events.retired);
      except_q  <= except_q + perf_cnt_t'(events.excepted);
    end
  end

  // ------------------------------------------------------------------
  // read mux
  // ------------------------------------------------------------------
  always_comb begin
    case (perf_addr_i)
      PERF_CYCLE:   perf_rdata_o = cycle_q;
      PERF_INSTRET: perf_rdata_o = instret_q;
      PERF_EXCEPT:  perf_rdata_o = except_q;
      // unused code
      default:      perf_rdata_o = '0;
    endcase
  end

endmodule

// ==== src/retire_trace.sv ====
// ----------------------------------------------------------------------
// retire trace top; the trace stream has no back-pressure
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "retire_params.svh"

module retire_trace (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic [`RETIRE_PORTS-1:0]                         commit_ack_i,
  input  logic [`RETIRE_PORTS-1:0][`RETIRE_PC_W-1:0]       commit_pc_i,
  input  logic [`RETIRE_PORTS-1:0]                         commit_ex_valid_i,
  input  logic [`RETIRE_PORTS-1:0][`RETIRE_CAUSE_W-1:0]    commit_ex_cause_i,
  input  logic [1:0]                                       priv_lvl_i,
  input  logic                                             debug_mode_i,
  input  logic [1:0]                                       perf_addr_i,
  output logic                                             trace_valid_o,
  output logic [`RETIRE_PC_W-1:0]                          trace_pc_o,
  output logic [1:0]                                       trace_mode_o,
  output logic                                             overflow_o,
  output logic [`RETIRE_CNT_W-1:0]                         perf_rdata_o
);
  import retire_pkg::*;
  import perf_pkg::*;

  commit_port_t [`RETIRE_PORTS-1:0] commit;
  trace_entry_t                     trace_entry;

  retire_push_if push_if ();
  perf_event_if  event_if ();

  // pack the plain commit ports
  for (genvar i = 0; i < `RETIRE_PORTS; i++) begin : g_pack
    assign commit[i] = '{
      ack:      commit_ack_i[i],
      pc:       commit_pc_i[i],
      ex_valid: commit_ex_valid_i[i],
      ex_cause: commit_ex_cause_i[i]
    };
  end

  // ------------------------------------------------------------------
  // instances
  // ------------------------------------------------------------------
  retire_ctrl i_retire_ctrl (
    .clk_i        ( clk_i                   ),
    .rst_ni       ( rst_ni                  ),
    .commit_i     ( commit                  ),
    .priv_lvl_i   ( priv_lvl_e'(priv_lvl_i) ),
    .debug_mode_i ( debug_mode_i            ),
    .push         ( push_if                 ),
    .events       ( event_if                )
  );

  pc_queue i_pc_queue (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .push          ( push_if       ),
    .trace_valid_o ( trace_valid_o ),
    .trace_entry_o ( trace_entry   ),
    .overflow_o    ( overflow_o    )
  );

  perf_counters i_perf_counters (
    .clk_i        ( clk_i                     ),
    .rst_ni       ( rst_ni                    ),
    .events       ( event_if                  ),
    .perf_addr_i  ( perf_addr_e'(perf_addr_i) ),
    .perf_rdata_o ( perf_rdata_o              )
  );

  // split the trace entry back out
  assign trace_pc_o   = trace_entry.pc;
  assign trace_mode_o = trace_entry.mode;

endmodule

// ==== sim/tb_retire_tasks.svh ====
// ----------------------------------------------------------------------
// test and compare tasks; every task returns 2 ns after a rising edge
// ----------------------------------------------------------------------

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic check_entry(input string name, input trace_entry_t got, input trace_entry_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic check_count(input string name, input perf_cnt_t got, input perf_cnt_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH %s: got %h, expected %h", name, got, exp);
  end
endtask

// ----------------------------------------------------------------------
// drive helpers
// ----------------------------------------------------------------------
task automatic next_cycle();
  @(posedge clk_i);
  #2;
endtask

task automatic reset_dut();
  rst_ni = 1'b0;
  repeat (8) @(posedge clk_i);
  #2;
  rst_ni = 1'b1;
endtask

task automatic idle_ports();
  commit_ack      = '0;
  commit_pc       = '0;
  commit_ex_valid = '0;
  commit_ex_cause = '0;
endtask

// random pc and cause on one port
task automatic drive_port(input int p, input logic ex);
  commit_ack[p]      = 1'b1;
  commit_pc[p]       = take_bits(`RETIRE_PC_W);
  commit_ex_valid[p] = ex;
  commit_ex_cause[p] = `RETIRE_CAUSE_W'(take_bits(`RETIRE_CAUSE_W));
endtask

task automatic read_counter(input logic [1:0] addr, output perf_cnt_t v);
  perf_addr = addr;
  #1;
  v = perf_rdata;
endtask

task automatic finish_test(input string name, input int start);
  tests++;
  $display("test %s finished with %0d errors", name, errors - start);
endtask

// ----------------------------------------------------------------------
// tests
// ----------------------------------------------------------------------
task automatic test_single_retire();
  int           start;
  trace_entry_t e0;
  start    = errors;
  priv_lvl = PRIV_M;
  drive_port(0, 1'b0);
  e0 = '{pc: commit_pc[0], mode: MODE_M};
  next_cycle();
  idle_ports();
  check_flag("trace_valid_o", trace_valid, 1'b1);
  check_entry("trace_entry", trace_got, e0);
  next_cycle();
  // shown for one cycle only
  check_flag("trace_valid_o", trace_valid, 1'b0);
  finish_test("single_retire", start);
endtask

task automatic test_dual_retire();
  int           start;
  trace_entry_t e0;
  trace_entry_t e1;
  trace_entry_t e2;
  start    = errors;
  priv_lvl = PRIV_S;
  drive_port(0, 1'b0);
  drive_port(1, 1'b0);
  e0 = '{pc: commit_pc[0], mode: MODE_S};
  e1 = '{pc: commit_pc[1], mode: MODE_S};
  next_cycle();
  idle_ports();
  priv_lvl = PRIV_U;
  drive_port(0, 1'b0);
  e2 = '{pc: commit_pc[0], mode: MODE_U};
  check_entry("trace_entry port 0", trace_got, e0);
  next_cycle();
  idle_ports();
  check_entry("trace_entry port 1", trace_got, e1);
  next_cycle();
  check_entry("trace_entry user", trace_got, e2);
  next_cycle();
  priv_lvl = PRIV_M;
  finish_test("dual_retire", start);
endtask

task automatic test_exceptions();
  int           start;
  perf_cnt_t    ret0;
  perf_cnt_t    exc0;
  perf_cnt_t    val;
  trace_entry_t e1;
  start = errors;
  read_counter(PERF_INSTRET, ret0);
  next_cycle();
  read_counter(PERF_EXCEPT, exc0);
  next_cycle();
  drive_port(0, 1'b1);
  drive_port(1, 1'b0);
  e1 = '{pc: commit_pc[1], mode: MODE_M};
  next_cycle();
  // both ports excepting
  drive_port(0, 1'b1);
  drive_port(1, 1'b1);
  check_flag("trace_valid_o", trace_valid, 1'b1);
  check_entry("trace_entry", trace_got, e1);
  next_cycle();
  idle_ports();
  check_flag("trace_valid_o", trace_valid, 1'b0);
  read_counter(PERF_INSTRET, val);
  check_count("instret", val, ret0 + 1);
  next_cycle();
  read_counter(PERF_EXCEPT, val);
  check_count("except", val, exc0 + 3);
  next_cycle();
  finish_test("exceptions", start);
endtask

task automatic test_debug_freeze();
  int           start;
  perf_cnt_t    cyc0;
  perf_cnt_t    ret0;
  perf_cnt_t    exc0;
  perf_cnt_t    val;
  trace_entry_t e0;
  start      = errors;
  debug_mode = 1'b1;
  next_cycle();
  read_counter(PERF_CYCLE, cyc0);
  next_cycle();
  read_counter(PERF_INSTRET, ret0);
  next_cycle();
  read_counter(PERF_EXCEPT, exc0);
  next_cycle();
  drive_port(0, 1'b0);
  drive_port(1, 1'b1);
  e0 = '{pc: commit_pc[0], mode: MODE_D};
  next_cycle();
  idle_ports();
  check_entry("trace_entry", trace_got, e0);
  read_counter(PERF_CYCLE, val);
  check_count("cycle", val, cyc0);
  next_cycle();
  read_counter(PERF_INSTRET, val);
  check_count("instret", val, ret0);
  next_cycle();
  read_counter(PERF_EXCEPT, val);
  check_count("except", val, exc0);
  next_cycle();
  debug_mode = 1'b0;
  finish_test("debug_freeze", start);
endtask

task automatic test_overflow();
  int start;
  start    = errors;
  accepted = 0;
  observed = 0;
  for (int i = 0; i < 10; i++) begin
    drive_port(0, 1'b0);
    drive_port(1, 1'b0);
    next_cycle();
  end
  idle_ports();
  check_flag("overflow_o", overflow, 1'b1);
  while (trace_valid) begin
    next_cycle();
  end
  check_count("traced entries", perf_cnt_t'(observed), perf_cnt_t'(accepted));
  check_flag("overflow_o", overflow, 1'b1);
  reset_dut();
  check_flag("overflow_o", overflow, 1'b0);
  finish_test("overflow", start);
endtask

task automatic test_counter_reads();
  int        start;
  perf_cnt_t cyc0;
  perf_cnt_t val;
  start = errors;
  // one retire and one exception so that no counter sits at zero
  drive_port(0, 1'b0);
  drive_port(1, 1'b1);
  next_cycle();
  idle_ports();
  read_counter(PERF_CYCLE, cyc0);
  repeat (5) next_cycle();
  read_counter(PERF_CYCLE, val);
  check_flag("cycle increase", val > cyc0, 1'b1);
  check_count("cycle", val, cyc0 + 5);
  read_counter(2'b11, val);
  check_count("perf_rdata_o unused", val, '0);
  next_cycle();
  finish_test("counter_reads", start);
endtask

// ==== sim/tb_retire_trace.sv ====
// ----------------------------------------------------------------------
// testbench for retire_trace; the reference queue models pops and drops
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`include "retire_params.svh"

module tb_retire_trace;
  import retire_pkg::*;
  import perf_pkg::*;

  localparam int TEST_CYCLES = 200;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic                                          clk_i;
  logic                                          rst_ni;
  logic [`RETIRE_PORTS-1:0]                      commit_ack;
  logic [`RETIRE_PORTS-1:0][`RETIRE_PC_W-1:0]    commit_pc;
  logic [`RETIRE_PORTS-1:0]                      commit_ex_valid;
  logic [`RETIRE_PORTS-1:0][`RETIRE_CAUSE_W-1:0] commit_ex_cause;
  logic [1:0]                                    priv_lvl;
  logic                                          debug_mode;
  logic [1:0]                                    perf_addr;
  logic                                          trace_valid;
  logic [`RETIRE_PC_W-1:0]                       trace_pc;
  logic [1:0]                                    trace_mode;
  logic                                          overflow;
  perf_cnt_t                                     perf_rdata;
  trace_entry_t                                  trace_got;

  int           errors   = 0;
  int           checks   = 0;
  int           tests    = 0;
  int           cycles   = 0;
  int           accepted = 0;
  int           observed = 0;
  logic [31:0]  lfsr_q;
  trace_entry_t ref_q[$];
  logic         ref_ovf;

  retire_trace dut (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .commit_ack_i      ( commit_ack      ),
    .commit_pc_i       ( commit_pc       ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_ex_cause_i ( commit_ex_cause ),
    .priv_lvl_i        ( priv_lvl        ),
    .debug_mode_i      ( debug_mode      ),
    .perf_addr_i       ( perf_addr       ),
    .trace_valid_o     ( trace_valid     ),
    .trace_pc_o        ( trace_pc        ),
    .trace_mode_o      ( trace_mode      ),
    .overflow_o        ( overflow        ),
    .perf_rdata_o      ( perf_rdata      )
  );

  assign trace_got = trace_entry_t'({trace_pc, trace_mode});

  `include "tb_retire_tasks.svh"

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // mode tag expected for the current inputs
  function automatic mode_e exp_mode();
    if (debug_mode) begin
      return MODE_D;
    end
    case (priv_lvl)
      2'b00:   return MODE_U;
      2'b01:   return MODE_S;
      default: return MODE_M;
    endcase
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // reference queue updated at the edge and compared 1 ns later
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin : ref_model
    if (!rst_ni) begin
      ref_q.delete();
      ref_ovf = 1'b0;
    end else begin
      if (ref_q.size() != 0) begin
        void'(ref_q.pop_front());
      end
      for (int i = 0; i < `RETIRE_PORTS; i++) begin
        if (commit_ack[i] && !commit_ex_valid[i]) begin
          if (ref_q.size() < `RETIRE_QDEPTH) begin
            ref_q.push_back('{pc: commit_pc[i], mode: exp_mode()});
            accepted++;
          end else begin
            ref_ovf = 1'b1;
          end
        end
      end
    end
    #1;
    if (rst_ni) begin
      check_flag("trace_valid_o", trace_valid, ref_q.size() != 0);
      if (ref_q.size() != 0) begin
        check_entry("trace_entry", trace_got, ref_q[0]);
      end
      check_flag("overflow_o", overflow, ref_ovf);
      if (trace_valid === 1'b1) begin
        observed++;
      end
    end
  end

  initial begin
    lfsr_q     = 32'hc24;
    rst_ni     = 1'b0;
    priv_lvl   = PRIV_M;
    debug_mode = 1'b0;
    perf_addr  = PERF_CYCLE;
    idle_ports();
    reset_dut();
    test_single_retire();
    test_dual_retire();
    test_exceptions();
    test_debug_freeze();
    test_overflow();
    test_counter_reads();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+src
+incdir+sim
src/retire_pkg.sv
src/perf_pkg.sv
src/retire_ifs.sv
src/retire_ctrl.sv
src/pc_queue.sv
src/perf_counters.sv
src/retire_trace.sv
sim/tb_retire_trace.sv

// ==== Makefile ====
# Verilator build and run of the retire trace testbench
TOP = tb_retire_trace

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP) > sim.log
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
